/* hdl/dram_traffic_pkg.sv */
package dram_traffic_pkg;

    // burst address width with one address per 128-bit memory word
    parameter int ADDR_W = 24;

    // memory word width
    parameter int DATA_W = 128;

    // wrapping activity counter width
    parameter int COUNT_W = 16;

    typedef logic [ADDR_W-1:0] mem_addr_t;
    typedef logic [DATA_W-1:0] mem_data_t;
    typedef logic [COUNT_W-1:0] count_t;

    // operation carried by one memory request
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // arbiter phases
    // load takes write beats, play takes read addresses,
    // wait holds a request on the bus until stall drops
    typedef enum logic [1:0] {
        ARB_LOAD = 2'd0,
        ARB_PLAY = 2'd1,
        ARB_WAIT = 2'd2
    } arb_state_e;

endpackage

/* hdl/req_track_if.sv */
interface req_track_if;

    // pulses in the cycle the memory bus accepts a request
    logic issue;
    // op and address of the accepted request
    dram_traffic_pkg::mem_op_e op;
    dram_traffic_pkg::mem_addr_t addr;
    // outstanding plus buffered responses at depth
    logic full;

    modport arbiter (
        output issue,
        output op,
        output addr,
        input  full
    );

    modport tracker (
        input  issue,
        input  op,
        input  addr,
        output full
    );

endinterface

/* hdl/request_arbiter.sv */
module request_arbiter #(
    parameter int TRACK_DEPTH = 4
) (
    input  logic                        clk_dram_ctrl,
    input  logic                        rst,

    input  logic                        i_wr_valid,
    input  dram_traffic_pkg::mem_data_t i_wr_data,
    input  logic                        i_wr_last,
    output logic                        o_wr_ready,

    input  logic                        i_rd_addr_valid,
    input  dram_traffic_pkg::mem_addr_t i_rd_addr,
    output logic                        o_rd_addr_ready,

    output logic                        o_mem_en,
    output logic                        o_mem_we,
    output dram_traffic_pkg::mem_addr_t o_mem_addr,
    output dram_traffic_pkg::mem_data_t o_mem_wdata,
    input  logic                        i_mem_busy,

    output logic                        o_load_complete,

    req_track_if.arbiter                trk
);

    dram_traffic_pkg::arb_state_e state;
    dram_traffic_pkg::arb_state_e next_state;
    dram_traffic_pkg::mem_op_e    req_op;
    dram_traffic_pkg::mem_addr_t  wr_addr;
    logic                         wr_ready_q;
    logic                         rd_ready_q;
    logic                         pending_last;
    logic                         wr_fire;
    logic                         rd_fire;
    logic                         bus_accept;

    // registered phase enables gated by tracker space
    assign o_wr_ready      = wr_ready_q && !trk.full;
    assign o_rd_addr_ready = rd_ready_q && !trk.full;

    assign wr_fire    = i_wr_valid && o_wr_ready;
    assign rd_fire    = i_rd_addr_valid && o_rd_addr_ready;
    // stall low while strobe is up takes the request
    assign bus_accept = o_mem_en && !i_mem_busy;

    assign o_mem_we = (req_op == dram_traffic_pkg::MEM_WRITE);

    // record every accepted request for the tracker
    assign trk.issue = bus_accept;
    assign trk.op    = req_op;
    assign trk.addr  = o_mem_addr;

    always_comb begin
        next_state = state;
        case (state)
            dram_traffic_pkg::ARB_LOAD: begin
                if (wr_fire) begin
                    next_state = dram_traffic_pkg::ARB_WAIT;
                end
            end
            dram_traffic_pkg::ARB_PLAY: begin
                if (rd_fire) begin
                    next_state = dram_traffic_pkg::ARB_WAIT;
                end
            end
            dram_traffic_pkg::ARB_WAIT: begin
                // back to loading unless the last beat just went out
                if (bus_accept) begin
                    next_state = (o_load_complete || pending_last) ?
                                 dram_traffic_pkg::ARB_PLAY : dram_traffic_pkg::ARB_LOAD;
                end
            end
            default: begin
                next_state = dram_traffic_pkg::ARB_LOAD;
            end
        endcase
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst) begin
            state           <= dram_traffic_pkg::ARB_LOAD;
            wr_ready_q      <= 1'b0;
            rd_ready_q      <= 1'b0;
            o_mem_en        <= 1'b0;
            o_load_complete <= 1'b0;
            pending_last    <= 1'b0;
            wr_addr         <= '0;
        end else begin
            state      <= next_state;
            // writes only in load and reads only in play
            wr_ready_q <= (next_state == dram_traffic_pkg::ARB_LOAD);
            rd_ready_q <= (next_state == dram_traffic_pkg::ARB_PLAY);
            if (wr_fire || rd_fire) begin
                o_mem_en <= 1'b1;
            end else if (bus_accept) begin
                o_mem_en <= 1'b0;
            end
            // sequential burst addresses from zero
            if (wr_fire) begin
                wr_addr      <= wr_addr + 1'b1;
                pending_last <= i_wr_last;
            end
            // load ends once the last beat leaves on the bus and never clears
            if (bus_accept && pending_last) begin
                o_load_complete <= 1'b1;
                pending_last    <= 1'b0;
            end
        end
    end

    // request fields held until the bus takes them
    always_ff @(posedge clk_dram_ctrl) begin
        if (wr_fire) begin
            req_op      <= dram_traffic_pkg::MEM_WRITE;
            o_mem_addr  <= wr_addr;
            o_mem_wdata <= i_wr_data;
        end else if (rd_fire) begin
            req_op     <= dram_traffic_pkg::MEM_READ;
            o_mem_addr <= i_rd_addr;
        end
    end

endmodule

/* hdl/response_tracker.sv */
module response_tracker #(
    parameter int TRACK_DEPTH = 4
) (
    input  logic                        clk_dram_ctrl,
    input  logic                        rst,

    input  logic                        i_mem_complete,
    input  dram_traffic_pkg::mem_data_t i_mem_rdata,

    output logic                        o_rd_valid,
    output dram_traffic_pkg::mem_addr_t o_rd_addr,
    output dram_traffic_pkg::mem_data_t o_rd_data,
    input  logic                        i_rd_ready,

    req_track_if.tracker                trk
);

    localparam int PTR_W = $clog2(TRACK_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    // issue-order queue of outstanding requests
    dram_traffic_pkg::mem_op_e   op_q   [TRACK_DEPTH];
    dram_traffic_pkg::mem_addr_t addr_q [TRACK_DEPTH];
    // read responses waiting for the read-data stream
    dram_traffic_pkg::mem_addr_t rsp_addr [TRACK_DEPTH];
    dram_traffic_pkg::mem_data_t rsp_data [TRACK_DEPTH];

    logic [PTR_W-1:0] q_wr_ptr;
    logic [PTR_W-1:0] q_rd_ptr;
    logic [PTR_W-1:0] b_wr_ptr;
    logic [PTR_W-1:0] b_rd_ptr;
    logic [CNT_W-1:0] q_count;
    logic [CNT_W-1:0] b_count;
    logic [CNT_W:0]   occupancy;
    logic             rsp_push;
    logic             rsp_pop;

    // oldest entry answers each completion and writes are dropped
    assign rsp_push = i_mem_complete && (op_q[q_rd_ptr] == dram_traffic_pkg::MEM_READ);
    assign rsp_pop  = o_rd_valid && i_rd_ready;

    // one slot per request from issue until its data leaves
    assign occupancy = {1'b0, q_count} + {1'b0, b_count};
    assign trk.full  = (occupancy >= (CNT_W + 1)'(TRACK_DEPTH));

    assign o_rd_valid = (b_count != '0);
    assign o_rd_addr  = rsp_addr[b_rd_ptr];
    assign o_rd_data  = rsp_data[b_rd_ptr];

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst) begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            b_wr_ptr <= '0;
            b_rd_ptr <= '0;
            q_count  <= '0;
            b_count  <= '0;
        end else begin
            if (trk.issue) begin
                q_wr_ptr <= q_wr_ptr + 1'b1;
            end
            if (i_mem_complete) begin
                q_rd_ptr <= q_rd_ptr + 1'b1;
            end
            // issue and completion can land together
            case ({trk.issue, i_mem_complete})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
            if (rsp_push) begin
                b_wr_ptr <= b_wr_ptr + 1'b1;
            end
            if (rsp_pop) begin
                b_rd_ptr <= b_rd_ptr + 1'b1;
            end
            case ({rsp_push, rsp_pop})
                2'b10:   b_count <= b_count + 1'b1;
                2'b01:   b_count <= b_count - 1'b1;
                default: b_count <= b_count;
            endcase
        end
    end

    // storage arrays
    always_ff @(posedge clk_dram_ctrl) begin
        if (trk.issue) begin
            op_q[q_wr_ptr]   <= trk.op;
            addr_q[q_wr_ptr] <= trk.addr;
        end
        // tag read data with the address it was issued for
        if (rsp_push) begin
            rsp_addr[b_wr_ptr] <= addr_q[q_rd_ptr];
            rsp_data[b_wr_ptr] <= i_mem_rdata;
        end
    end

endmodule

/* hdl/activity_counters.sv */
module activity_counters (
    input  logic                     clk_dram_ctrl,
    input  logic                     rst,

    input  logic                     i_mem_complete,
    input  logic                     i_rd_fire,

    output dram_traffic_pkg::count_t o_complete_count,
    output dram_traffic_pkg::count_t o_rd_count
);

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst) begin
            o_complete_count <= '0;
            o_rd_count       <= '0;
        end else begin
            // every ack from memory for reads and writes alike
            if (i_mem_complete) begin
                o_complete_count <= o_complete_count + 1'b1;
            end
            // read data actually taken by the consumer
            if (i_rd_fire) begin
                o_rd_count <= o_rd_count + 1'b1;
            end
        end
    end

endmodule

/* hdl/dram_traffic_top.sv */
module dram_traffic_top #(
    parameter int TRACK_DEPTH = 4
) (
    input  logic                        clk_dram_ctrl,
    input  logic                        rst,

    // sample load stream
    input  logic                        i_wr_valid,
    input  dram_traffic_pkg::mem_data_t i_wr_data,
    input  logic                        i_wr_last,
    output logic                        o_wr_ready,

    // playback read addresses
    input  logic                        i_rd_addr_valid,
    input  dram_traffic_pkg::mem_addr_t i_rd_addr,
    output logic                        o_rd_addr_ready,

    // tagged read data
    output logic                        o_rd_valid,
    output dram_traffic_pkg::mem_addr_t o_rd_addr,
    output dram_traffic_pkg::mem_data_t o_rd_data,
    input  logic                        i_rd_ready,

    // memory request bus
    output logic                        o_mem_en,
    output logic                        o_mem_we,
    output dram_traffic_pkg::mem_addr_t o_mem_addr,
    output dram_traffic_pkg::mem_data_t o_mem_wdata,
    input  logic                        i_mem_busy,
    input  logic                        i_mem_complete,
    input  dram_traffic_pkg::mem_data_t i_mem_rdata,

    // status
    output logic                        o_load_complete,
    output dram_traffic_pkg::count_t    o_complete_count,
    output dram_traffic_pkg::count_t    o_rd_count
);

    logic rd_fire;

    // issued request records, arbiter to tracker
    req_track_if trk_if ();

    // read-data handshake for the delivered count
    assign rd_fire = o_rd_valid && i_rd_ready;

    request_arbiter #(
        .TRACK_DEPTH     (TRACK_DEPTH)
    ) u_arbiter (
        .clk_dram_ctrl   (clk_dram_ctrl),
        .rst             (rst),
        .i_wr_valid      (i_wr_valid),
        .i_wr_data       (i_wr_data),
        .i_wr_last       (i_wr_last),
        .o_wr_ready      (o_wr_ready),
        .i_rd_addr_valid (i_rd_addr_valid),
        .i_rd_addr       (i_rd_addr),
        .o_rd_addr_ready (o_rd_addr_ready),
        .o_mem_en        (o_mem_en),
        .o_mem_we        (o_mem_we),
        .o_mem_addr      (o_mem_addr),
        .o_mem_wdata     (o_mem_wdata),
        .i_mem_busy      (i_mem_busy),
        .o_load_complete (o_load_complete),
        .trk             (trk_if.arbiter)
    );

    response_tracker #(
        .TRACK_DEPTH    (TRACK_DEPTH)
    ) u_tracker (
        .clk_dram_ctrl  (clk_dram_ctrl),
        .rst            (rst),
        .i_mem_complete (i_mem_complete),
        .i_mem_rdata    (i_mem_rdata),
        .o_rd_valid     (o_rd_valid),
        .o_rd_addr      (o_rd_addr),
        .o_rd_data      (o_rd_data),
        .i_rd_ready     (i_rd_ready),
        .trk            (trk_if.tracker)
    );

    activity_counters u_counters (
        .clk_dram_ctrl    (clk_dram_ctrl),
        .rst              (rst),
        .i_mem_complete   (i_mem_complete),
        .i_rd_fire        (rd_fire),
        .o_complete_count (o_complete_count),
        .o_rd_count       (o_rd_count)
    );

endmodule

/* verification/dram_model.sv */
module dram_model (
    input  logic                        clk_dram_ctrl,
    input  logic                        rst,
    input  logic                        i_mem_en,
    input  logic                        i_mem_we,
    input  dram_traffic_pkg::mem_addr_t i_mem_addr,
    input  dram_traffic_pkg::mem_data_t i_mem_wdata,
    output logic                        o_mem_busy,
    output logic                        o_mem_complete,
    output dram_traffic_pkg::mem_data_t o_mem_rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    // word store on the low address bits
    dram_traffic_pkg::mem_data_t mem [256];
    // accepted requests waiting for their completion cycle
    int                          due_q [$];
    dram_traffic_pkg::mem_data_t rdata_q [$];
    integer seed = 87;
    int     cycle = 0;
    int     last_due = 0;
    int     due;
    bit     accept;
    bit     in_reset;

    initial begin
        o_mem_busy     = 1'b0;
        o_mem_complete = 1'b0;
        o_mem_rdata    = '0;
        for (int k = 0; k < 256; k++) begin
            mem[k] = '0;
        end
    end

    always @(posedge clk_dram_ctrl) begin
        // request taken at the edge and answered 10 ns later
        in_reset = rst;
        accept   = i_mem_en && !o_mem_busy && !rst;
        cycle    = cycle + 1;
        if (accept) begin
            if (i_mem_we) begin
                mem[i_mem_addr[7:0]] = i_mem_wdata;
            end
            // 1 to 3 cycles and never ahead of the one before
            due = cycle + 1 + (($random(seed) & 32'h7fffffff) % 3);
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            due_q.push_back(due);
            rdata_q.push_back(i_mem_we ? '0 : mem[i_mem_addr[7:0]]);
        end
        #10;
        if (in_reset) begin
            due_q.delete();
            rdata_q.delete();
            o_mem_complete = 1'b0;
            o_mem_busy     = 1'b0;
        end else begin
            if (due_q.size() != 0 && due_q[0] <= cycle) begin
                due            = due_q.pop_front();
                o_mem_complete = 1'b1;
                o_mem_rdata    = rdata_q.pop_front();
            end else begin
                o_mem_complete = 1'b0;
            end
            // stall roughly one cycle in four
            o_mem_busy = (($random(seed) & 3) == 0);
        end
    end

endmodule

/* verification/tb_dram_traffic.sv */
module tb_dram_traffic;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_REC = 64;

    logic                        clk_dram_ctrl;
    logic                        rst;
    logic                        i_wr_valid;
    dram_traffic_pkg::mem_data_t i_wr_data;
    logic                        i_wr_last;
    logic                        o_wr_ready;
    logic                        i_rd_addr_valid;
    dram_traffic_pkg::mem_addr_t i_rd_addr;
    logic                        o_rd_addr_ready;
    logic                        o_rd_valid;
    dram_traffic_pkg::mem_addr_t o_rd_addr;
    dram_traffic_pkg::mem_data_t o_rd_data;
    logic                        i_rd_ready;
    logic                        o_mem_en;
    logic                        o_mem_we;
    dram_traffic_pkg::mem_addr_t o_mem_addr;
    dram_traffic_pkg::mem_data_t o_mem_wdata;
    logic                        i_mem_busy;
    logic                        i_mem_complete;
    dram_traffic_pkg::mem_data_t i_mem_rdata;
    logic                        o_load_complete;
    dram_traffic_pkg::count_t    o_complete_count;
    dram_traffic_pkg::count_t    o_rd_count;

    // record layout kind[163:160] arg[159:152] addr[151:128] data[127:0]
    logic [163:0]                stim [MAX_REC];
    dram_traffic_pkg::mem_data_t wr_beats [$];
    dram_traffic_pkg::mem_addr_t exp_addr_q [$];
    dram_traffic_pkg::mem_data_t exp_data_q [$];
    dram_traffic_pkg::count_t    exp_count;
    string cur_test = "reset";
    int n_rec;
    int idx;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_start;
    int cycle_count = 0;
    int cycle_limit = 0;
    int rd_sent = 0;
    int rd_got = 0;
    int block_run = 0;
    bit last_accepted = 1'b0;
    bit load_seen = 1'b0;
    bit saw_block = 1'b0;

    dram_traffic_top #(
        .TRACK_DEPTH      (4)
    ) i_dut (
        .clk_dram_ctrl    (clk_dram_ctrl),
        .rst              (rst),
        .i_wr_valid       (i_wr_valid),
        .i_wr_data        (i_wr_data),
        .i_wr_last        (i_wr_last),
        .o_wr_ready       (o_wr_ready),
        .i_rd_addr_valid  (i_rd_addr_valid),
        .i_rd_addr        (i_rd_addr),
        .o_rd_addr_ready  (o_rd_addr_ready),
        .o_rd_valid       (o_rd_valid),
        .o_rd_addr        (o_rd_addr),
        .o_rd_data        (o_rd_data),
        .i_rd_ready       (i_rd_ready),
        .o_mem_en         (o_mem_en),
        .o_mem_we         (o_mem_we),
        .o_mem_addr       (o_mem_addr),
        .o_mem_wdata      (o_mem_wdata),
        .i_mem_busy       (i_mem_busy),
        .i_mem_complete   (i_mem_complete),
        .i_mem_rdata      (i_mem_rdata),
        .o_load_complete  (o_load_complete),
        .o_complete_count (o_complete_count),
        .o_rd_count       (o_rd_count)
    );

    dram_model mem_model (
        .clk_dram_ctrl  (clk_dram_ctrl),
        .rst            (rst),
        .i_mem_en       (o_mem_en),
        .i_mem_we       (o_mem_we),
        .i_mem_addr     (o_mem_addr),
        .i_mem_wdata    (o_mem_wdata),
        .o_mem_busy     (i_mem_busy),
        .o_mem_complete (i_mem_complete),
        .o_mem_rdata    (i_mem_rdata)
    );

    initial begin
        clk_dram_ctrl = 1'b0;
        forever #50 clk_dram_ctrl = ~clk_dram_ctrl;
    end

    // run limit set once the stimulus is read
    initial begin
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk_dram_ctrl);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Test failed");
        $finish;
    end

    task automatic check_addr(input string name, input dram_traffic_pkg::mem_addr_t exp,
                              input dram_traffic_pkg::mem_addr_t act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s, %s: expected %h, actual %h",
                     cur_test, name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input dram_traffic_pkg::mem_data_t exp,
                              input dram_traffic_pkg::mem_data_t act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s, %s: expected %h, actual %h",
                     cur_test, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input dram_traffic_pkg::count_t exp,
                               input dram_traffic_pkg::count_t act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s, %s: expected %0d, actual %0d",
                     cur_test, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input bit exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s, %s: expected %b, actual %b",
                     cur_test, name, exp, act);
        end
    endtask

    task automatic report_test(input int start);
        tests_run++;
        if (errors > start) begin
            tests_failed++;
            $display("test %s: FAIL, %0d errors", cur_test, errors - start);
        end else begin
            $display("test %s: pass", cur_test);
        end
    endtask

    // holds the beat until the handshake and returns at edge plus 10 ns
    task automatic send_write(input dram_traffic_pkg::mem_data_t data, input bit last);
        bit fired;
        i_wr_valid = 1'b1;
        i_wr_data  = data;
        i_wr_last  = last;
        do begin
            @(negedge clk_dram_ctrl);
            fired = o_wr_ready;
            if (fired && last) begin
                last_accepted = 1'b1;
            end
            @(posedge clk_dram_ctrl);
            #10;
        end while (!fired);
        i_wr_valid = 1'b0;
        wr_beats.push_back(data);
    endtask

    task automatic send_read(input dram_traffic_pkg::mem_addr_t addr,
                             input dram_traffic_pkg::mem_data_t exp_data);
        bit fired;
        i_rd_addr_valid = 1'b1;
        i_rd_addr       = addr;
        do begin
            @(negedge clk_dram_ctrl);
            fired = o_rd_addr_ready;
            @(posedge clk_dram_ctrl);
            #10;
        end while (!fired);
        i_rd_addr_valid = 1'b0;
        // responses must come back in this order
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(exp_data);
        rd_sent++;
    endtask

    // consumer stalls in the background while reads keep coming
    task automatic hold_read_ready_low(input int cycles);
        i_rd_ready = 1'b0;
        fork
            begin
                repeat (cycles) @(posedge clk_dram_ctrl);
                #10;
                i_rd_ready = 1'b1;
            end
        join_none
    endtask

    // protocol watch and read-data scoreboard at mid-cycle
    always @(negedge clk_dram_ctrl) begin
        if (!rst) begin
            if (!o_load_complete && o_rd_addr_ready) begin
                errors++;
                $display("read address ready raised before the load completed");
            end
            if (o_load_complete && o_wr_ready) begin
                errors++;
                $display("write ready raised after the load completed");
            end
            if (o_load_complete && !last_accepted) begin
                errors++;
                $display("load complete raised before the last beat was taken");
            end
            if (load_seen && !o_load_complete) begin
                errors++;
                $display("load complete dropped without a reset");
            end
            load_seen = load_seen || o_load_complete;
            // long stall of a waiting read while the consumer is held off
            if (!i_rd_ready && i_rd_addr_valid && o_load_complete && !o_rd_addr_ready) begin
                block_run++;
            end else begin
                block_run = 0;
            end
            if (block_run >= 8) begin
                saw_block = 1'b1;
            end
            if (o_rd_valid && i_rd_ready) begin
                if (exp_addr_q.size() == 0) begin
                    errors++;
                    $display("read data delivered with no read outstanding");
                end else begin
                    check_addr("read tag", exp_addr_q.pop_front(), o_rd_addr);
                    check_data("read data", exp_data_q.pop_front(), o_rd_data);
                    rd_got++;
                end
            end
        end
    end

    initial begin
        rst             = 1'b1;
        i_wr_valid      = 1'b0;
        i_wr_data       = '0;
        i_wr_last       = 1'b0;
        i_rd_addr_valid = 1'b0;
        i_rd_addr       = '0;
        i_rd_ready      = 1'b1;
        for (int i = 0; i < MAX_REC; i++) begin
            stim[i] = '0;
        end
        $readmemh("verification/dram_traffic_stim.txt", stim);
        // kind zero ends the list
        n_rec = 0;
        while (n_rec < MAX_REC && stim[n_rec][163:160] != 4'h0) begin
            n_rec++;
        end
        cycle_limit = 20 * n_rec + 100;
        repeat (3) @(posedge clk_dram_ctrl);
        #10;
        rst = 1'b0;

        cur_test = "reads blocked before load";
        test_start = errors;
        i_rd_addr_valid = 1'b1;
        repeat (3) begin
            @(negedge clk_dram_ctrl);
            check_flag("read ready before load", 1'b0, o_rd_addr_ready);
            @(posedge clk_dram_ctrl);
            #10;
        end
        i_rd_addr_valid = 1'b0;
        report_test(test_start);

        cur_test = "load and write addressing";
        test_start = errors;
        idx = 0;
        while (idx < n_rec && stim[idx][163:160] == 4'h1) begin
            send_write(stim[idx][127:0], stim[idx][152]);
            idx++;
        end
        while (!o_load_complete) begin
            @(negedge clk_dram_ctrl);
        end
        // beat k belongs at burst address k
        for (int k = 0; k < wr_beats.size(); k++) begin
            check_data("stored word", wr_beats[k], mem_model.mem[k]);
        end
        @(posedge clk_dram_ctrl);
        #10;
        i_wr_valid = 1'b1;
        i_wr_data  = '1;
        repeat (3) begin
            @(negedge clk_dram_ctrl);
            check_flag("write ready after load", 1'b0, o_wr_ready);
            @(posedge clk_dram_ctrl);
            #10;
        end
        i_wr_valid = 1'b0;
        report_test(test_start);

        cur_test = "tagged read-back";
        test_start = errors;
        while (idx < n_rec) begin
            if (stim[idx][163:160] == 4'h2) begin
                send_read(stim[idx][151:128], stim[idx][127:0]);
            end else if (stim[idx][163:160] == 4'h3) begin
                hold_read_ready_low(stim[idx][159:152]);
            end
            idx++;
        end
        while (rd_got < rd_sent || !i_rd_ready) begin
            @(negedge clk_dram_ctrl);
        end
        // last handshake lands on the next edge
        @(posedge clk_dram_ctrl);
        @(negedge clk_dram_ctrl);
        report_test(test_start);

        cur_test = "back-pressure";
        test_start = errors;
        check_flag("read issue stalled by full tracker", 1'b1, saw_block);
        check_flag("no response left over", 1'b0, o_rd_valid);
        report_test(test_start);

        cur_test = "activity counters";
        test_start = errors;
        exp_count = wr_beats.size() + rd_sent;
        check_count("memory completions", exp_count, o_complete_count);
        exp_count = rd_sent;
        check_count("read responses", exp_count, o_rd_count);
        report_test(test_start);

        $display("tests run %0d, failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verification/dram_traffic_stim.txt */
// kind_arg_addr_data in hex, one record per line
// kind 1 write (arg = last flag), 2 read (addr, expected data), 3 pause (arg = cycles)
1_00_000000_0f1e2d3c4b5a69788796a5b4c3d2e1f0
1_00_000000_11112222333344445555666677778888
1_00_000000_deadbeef00000001cafef00d12345678
1_00_000000_0000000000000000ffffffffffffffff
1_00_000000_a5a5a5a55a5a5a5a3c3c3c3cc3c3c3c3
1_01_000000_0123456789abcdeffedcba9876543210
2_00_000002_deadbeef00000001cafef00d12345678
2_00_000000_0f1e2d3c4b5a69788796a5b4c3d2e1f0
2_00_000005_0123456789abcdeffedcba9876543210
3_28_000000_00000000000000000000000000000000
2_00_000001_11112222333344445555666677778888
2_00_000003_0000000000000000ffffffffffffffff
2_00_000004_a5a5a5a55a5a5a5a3c3c3c3cc3c3c3c3
2_00_000001_11112222333344445555666677778888
2_00_000002_deadbeef00000001cafef00d12345678
2_00_000000_0f1e2d3c4b5a69788796a5b4c3d2e1f0
2_00_000005_0123456789abcdeffedcba9876543210
2_00_000003_0000000000000000ffffffffffffffff
2_00_000004_a5a5a5a55a5a5a5a3c3c3c3cc3c3c3c3

/* dram_traffic.f */
hdl/dram_traffic_pkg.sv
hdl/req_track_if.sv
hdl/request_arbiter.sv
hdl/response_tracker.sv
hdl/activity_counters.sv
hdl/dram_traffic_top.sv
verification/dram_model.sv
verification/tb_dram_traffic.sv
